/* core_read_port.f */
+incdir+verif
hdl/axi_read_pkg.sv
hdl/core_req_pkg.sv
hdl/fetch_pair_tracker.sv
hdl/load_tracker.sv
hdl/read_channel_arbiter.sv
hdl/core_read_port.sv
verif/core_read_port_tb.sv

/* hdl/axi_read_pkg.sv */
package axi_read_pkg;

	//////////////////////////////
	// read address field widths
	//////////////////////////////
	localparam int ID_W = 4;
	localparam int LEN_W = 4;

	typedef logic [ID_W-1:0] axi_id_t;
	typedef logic [LEN_W-1:0] axi_len_t;

	// one id per read source
	localparam axi_id_t FETCH_ID = 4'd0;
	localparam axi_id_t LOAD_ID_1 = 4'd1;
	localparam axi_id_t LOAD_ID_2 = 4'd2;

	// arlen is beats minus one
	localparam axi_len_t FETCH_LEN = 4'd1;
	localparam axi_len_t LOAD_LEN = 4'd0;

	// fixed on the bus, so no ports for these
	localparam logic [2:0] AR_SIZE = 3'b010;
	localparam logic [1:0] AR_BURST = 2'b01;

	// 4 bytes per beat, incrementing
	localparam int BEAT_BYTES = 1 << AR_SIZE;

endpackage

/* hdl/core_read_port.sv */
`timescale 1ns/1ps

module core_read_port
(
	input  logic                    clk,
	input  logic                    reset,
	// core side
	input  logic                    fetch_strobe,
	input  core_req_pkg::addr_t     fetch_pc,
	input  logic                    load_strobe_1,
	input  core_req_pkg::addr_t     load_addr_1,
	input  logic                    load_strobe_2,
	input  core_req_pkg::addr_t     load_addr_2,
	output logic                    inst_valid,
	output core_req_pkg::word_t     inst_1,
	output core_req_pkg::word_t     inst_2,
	output logic                    load_valid_1,
	output core_req_pkg::word_t     load_data_1,
	output logic                    load_valid_2,
	output core_req_pkg::word_t     load_data_2,
	output logic                    fetch_pending,
	output logic                    load_pending_1,
	output logic                    load_pending_2,
	// read address channel
	output logic                    arvalid,
	output axi_read_pkg::axi_id_t   arid,
	output core_req_pkg::addr_t     araddr,
	output axi_read_pkg::axi_len_t  arlen,
	input  logic                    arready,
	// read data channel, always accepted
	input  logic                    rvalid,
	input  axi_read_pkg::axi_id_t   rid,
	input  core_req_pkg::word_t     rdata
);

	logic fetch_req;
	logic fetch_grant;
	core_req_pkg::addr_t fetch_addr;
	logic load_req_1;
	logic load_req_2;
	logic load_grant_1;
	logic load_grant_2;
	core_req_pkg::addr_t req_addr_1;
	core_req_pkg::addr_t req_addr_2;

	//////////////////////////////
	// request trackers
	//////////////////////////////
	fetch_pair_tracker i_fetch_pair_tracker
	(
		.clk           (clk),
		.reset         (reset),
		.fetch_strobe  (fetch_strobe),
		.fetch_pc      (fetch_pc),
		.fetch_grant   (fetch_grant),
		.rvalid        (rvalid),
		.rid           (rid),
		.rdata         (rdata),
		.fetch_req     (fetch_req),
		.fetch_addr    (fetch_addr),
		.fetch_pending (fetch_pending),
		.inst_valid    (inst_valid),
		.inst_1        (inst_1),
		.inst_2        (inst_2)
	);

	load_tracker i_load_tracker
	(
		.clk            (clk),
		.reset          (reset),
		.load_strobe_1  (load_strobe_1),
		.load_strobe_2  (load_strobe_2),
		.load_addr_in_1 (load_addr_1),
		.load_addr_in_2 (load_addr_2),
		.load_grant_1   (load_grant_1),
		.load_grant_2   (load_grant_2),
		.rvalid         (rvalid),
		.rid            (rid),
		.rdata          (rdata),
		.load_req_1     (load_req_1),
		.load_req_2     (load_req_2),
		.load_addr_1    (req_addr_1),
		.load_addr_2    (req_addr_2),
		.load_pending_1 (load_pending_1),
		.load_pending_2 (load_pending_2),
		.load_valid_1   (load_valid_1),
		.load_valid_2   (load_valid_2),
		.load_data_1    (load_data_1),
		.load_data_2    (load_data_2)
	);

	// single address channel shared by all three sources
	read_channel_arbiter i_read_channel_arbiter
	(
		.clk          (clk),
		.reset        (reset),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.load_req_1   (load_req_1),
		.load_req_2   (load_req_2),
		.load_addr_1  (req_addr_1),
		.load_addr_2  (req_addr_2),
		.arready      (arready),
		.fetch_grant  (fetch_grant),
		.load_grant_1 (load_grant_1),
		.load_grant_2 (load_grant_2),
		.arvalid      (arvalid),
		.arid         (arid),
		.araddr       (araddr),
		.arlen        (arlen)
	);

endmodule

/* hdl/core_req_pkg.sv */
package core_req_pkg;

	//////////////////////////////
	// core side of the read port
	//////////////////////////////
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;

	// byte address from the core
	typedef logic [ADDR_W-1:0] addr_t;

	// instruction or load data
	typedef logic [WORD_W-1:0] word_t;

	// dual issue
	localparam int LANES = 2;

endpackage

/* hdl/fetch_pair_tracker.sv */
`timescale 1ns/1ps

module fetch_pair_tracker
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   fetch_strobe,
	input  core_req_pkg::addr_t    fetch_pc,
	input  logic                   fetch_grant,
	input  logic                   rvalid,
	input  axi_read_pkg::axi_id_t  rid,
	input  core_req_pkg::word_t    rdata,
	output logic                   fetch_req,
	output core_req_pkg::addr_t    fetch_addr,
	output logic                   fetch_pending,
	output logic                   inst_valid,
	output core_req_pkg::word_t    inst_1,
	output core_req_pkg::word_t    inst_2
);

	typedef enum logic [1:0]
	{
		F_IDLE,
		F_REQ,
		F_RECV
	} fetch_state_t;

	fetch_state_t state;
	logic second_beat;
	logic fetch_beat;

	assign fetch_beat = rvalid && (rid == axi_read_pkg::FETCH_ID);
	assign fetch_req = (state == F_REQ);
	assign fetch_pending = (state != F_IDLE);

	//////////////////////////////
	// control
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= F_IDLE;
			second_beat <= 1'b0;
			inst_valid <= 1'b0;
		end
		else
		begin
			inst_valid <= 1'b0;
			case (state)
				F_IDLE:
					if (fetch_strobe)
						state <= F_REQ;
				F_REQ:
					if (fetch_grant)
						state <= F_RECV;
				F_RECV:
					if (fetch_beat)
					begin
						// flag flips back to first beat for the next pair
						second_beat <= !second_beat;
						if (second_beat)
						begin
							state <= F_IDLE;
							inst_valid <= 1'b1;
						end
					end
				default:
					state <= F_IDLE;
			endcase
		end
	end

	// pc and instruction pair
	always_ff @(posedge clk)
	begin
		if (state == F_IDLE && fetch_strobe)
			fetch_addr <= fetch_pc;
		if (state == F_RECV && fetch_beat)
		begin
			if (second_beat)
				inst_2 <= rdata;
			else
				inst_1 <= rdata;
		end
	end

	// core must wait for inst_valid before the next pair
	a_no_strobe_pending: assert property (@(posedge clk) disable iff (reset)
		fetch_strobe |-> !fetch_pending);

	// fetch beats only after the burst was granted
	a_beat_in_recv: assert property (@(posedge clk) disable iff (reset)
		fetch_beat |-> state == F_RECV);

endmodule

/* hdl/load_tracker.sv */
`timescale 1ns/1ps

module load_tracker
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   load_strobe_1,
	input  logic                   load_strobe_2,
	input  core_req_pkg::addr_t    load_addr_in_1,
	input  core_req_pkg::addr_t    load_addr_in_2,
	input  logic                   load_grant_1,
	input  logic                   load_grant_2,
	input  logic                   rvalid,
	input  axi_read_pkg::axi_id_t  rid,
	input  core_req_pkg::word_t    rdata,
	output logic                   load_req_1,
	output logic                   load_req_2,
	output core_req_pkg::addr_t    load_addr_1,
	output core_req_pkg::addr_t    load_addr_2,
	output logic                   load_pending_1,
	output logic                   load_pending_2,
	output logic                   load_valid_1,
	output logic                   load_valid_2,
	output core_req_pkg::word_t    load_data_1,
	output core_req_pkg::word_t    load_data_2
);

	typedef enum logic [1:0]
	{
		L_IDLE,
		L_REQ,
		L_RECV
	} lane_state_t;

	logic [core_req_pkg::LANES-1:0] strobe;
	logic [core_req_pkg::LANES-1:0] grant;
	logic [core_req_pkg::LANES-1:0] req;
	logic [core_req_pkg::LANES-1:0] pending;
	logic [core_req_pkg::LANES-1:0] valid;
	core_req_pkg::addr_t addr_in [core_req_pkg::LANES];
	core_req_pkg::addr_t addr [core_req_pkg::LANES];
	core_req_pkg::word_t data [core_req_pkg::LANES];
	axi_read_pkg::axi_id_t lane_id [core_req_pkg::LANES];

	// lane 1 sits at index 0
	assign strobe = {load_strobe_2, load_strobe_1};
	assign grant = {load_grant_2, load_grant_1};
	assign addr_in[0] = load_addr_in_1;
	assign addr_in[1] = load_addr_in_2;
	assign lane_id[0] = axi_read_pkg::LOAD_ID_1;
	assign lane_id[1] = axi_read_pkg::LOAD_ID_2;

	for (genvar i = 0; i < core_req_pkg::LANES; i++)
	begin : g_lane
		lane_state_t state;
		logic hit;
		logic valid_q;
		core_req_pkg::addr_t addr_q;
		core_req_pkg::word_t data_q;

		assign hit = rvalid && (rid == lane_id[i]);
		assign req[i] = (state == L_REQ);
		assign pending[i] = (state != L_IDLE);
		assign valid[i] = valid_q;
		assign addr[i] = addr_q;
		assign data[i] = data_q;

		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				state <= L_IDLE;
				valid_q <= 1'b0;
			end
			else
			begin
				valid_q <= 1'b0;
				case (state)
					L_IDLE:
						if (strobe[i])
							state <= L_REQ;
					L_REQ:
						if (grant[i])
							state <= L_RECV;
					L_RECV:
						if (hit)
						begin
							state <= L_IDLE;
							valid_q <= 1'b1;
						end
					default:
						state <= L_IDLE;
				endcase
			end
		end

		always_ff @(posedge clk)
		begin
			if (state == L_IDLE && strobe[i])
				addr_q <= addr_in[i];
			if (state == L_RECV && hit)
				data_q <= rdata;
		end

		a_no_strobe_pending: assert property (@(posedge clk) disable iff (reset)
			strobe[i] |-> !pending[i]);

		// single-beat reads, so one beat per grant
		a_beat_when_waiting: assert property (@(posedge clk) disable iff (reset)
			hit |-> state == L_RECV);
	end

	assign load_req_1 = req[0];
	assign load_req_2 = req[1];
	assign load_addr_1 = addr[0];
	assign load_addr_2 = addr[1];
	assign load_pending_1 = pending[0];
	assign load_pending_2 = pending[1];
	assign load_valid_1 = valid[0];
	assign load_valid_2 = valid[1];
	assign load_data_1 = data[0];
	assign load_data_2 = data[1];

endmodule

/* hdl/read_channel_arbiter.sv */
`timescale 1ns/1ps

module read_channel_arbiter
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    fetch_req,
	input  core_req_pkg::addr_t     fetch_addr,
	input  logic                    load_req_1,
	input  logic                    load_req_2,
	input  core_req_pkg::addr_t     load_addr_1,
	input  core_req_pkg::addr_t     load_addr_2,
	input  logic                    arready,
	output logic                    fetch_grant,
	output logic                    load_grant_1,
	output logic                    load_grant_2,
	output logic                    arvalid,
	output axi_read_pkg::axi_id_t   arid,
	output core_req_pkg::addr_t     araddr,
	output axi_read_pkg::axi_len_t  arlen
);

	logic handshake;
	logic ar_free;
	logic fetch_pick;
	logic load_pick_1;
	logic load_pick_2;

	assign handshake = arvalid && arready;
	assign ar_free = !arvalid || arready;

	//////////////////////////////
	// grants follow the latched id
	//////////////////////////////
	assign fetch_grant = handshake && (arid == axi_read_pkg::FETCH_ID);
	assign load_grant_1 = handshake && (arid == axi_read_pkg::LOAD_ID_1);
	assign load_grant_2 = handshake && (arid == axi_read_pkg::LOAD_ID_2);

	// the granted source still shows req this cycle and is left out
	assign fetch_pick = fetch_req && !fetch_grant;
	assign load_pick_1 = load_req_1 && !load_grant_1;
	assign load_pick_2 = load_req_2 && !load_grant_2;

	always_ff @(posedge clk)
	begin
		if (reset)
			arvalid <= 1'b0;
		else if (ar_free)
			arvalid <= fetch_pick || load_pick_1 || load_pick_2;
	end

	// fixed priority with fetch first
	always_ff @(posedge clk)
	begin
		if (ar_free)
		begin
			if (fetch_pick)
			begin
				arid <= axi_read_pkg::FETCH_ID;
				araddr <= fetch_addr;
				arlen <= axi_read_pkg::FETCH_LEN;
			end
			else if (load_pick_1)
			begin
				arid <= axi_read_pkg::LOAD_ID_1;
				araddr <= load_addr_1;
				arlen <= axi_read_pkg::LOAD_LEN;
			end
			else if (load_pick_2)
			begin
				arid <= axi_read_pkg::LOAD_ID_2;
				araddr <= load_addr_2;
				arlen <= axi_read_pkg::LOAD_LEN;
			end
		end
	end

	// waiting address phase still matches what its source holds
	a_ar_matches_source: assert property (@(posedge clk) disable iff (reset)
		arvalid |-> ((arid == axi_read_pkg::FETCH_ID)
			? (fetch_req && araddr == fetch_addr)
			: (arid == axi_read_pkg::LOAD_ID_1)
			? (load_req_1 && araddr == load_addr_1)
			: (load_req_2 && araddr == load_addr_2)));

endmodule

/* verif/core_read_port_checks.svh */
// slave data rule, one word per beat address
function automatic core_req_pkg::word_t slave_word(input core_req_pkg::addr_t beat_addr);
	return beat_addr ^ 32'h5A3C_96E1;
endfunction

//////////////////////////////
// compare tasks
//////////////////////////////
task automatic check_word(input string what, input core_req_pkg::word_t exp,
	input core_req_pkg::word_t act);
	if (exp !== act)
		report_failure($sformatf("CHECK FAILED %s: %s expected %h actual %h",
			test_name, what, exp, act));
endtask

task automatic check_addr(input string what, input core_req_pkg::addr_t exp,
	input core_req_pkg::addr_t act);
	if (exp !== act)
		report_failure($sformatf("CHECK FAILED %s: %s expected %h actual %h",
			test_name, what, exp, act));
endtask

task automatic check_id(input string what, input axi_read_pkg::axi_id_t exp,
	input axi_read_pkg::axi_id_t act);
	if (exp !== act)
		report_failure($sformatf("CHECK FAILED %s: %s expected %0d actual %0d",
			test_name, what, exp, act));
endtask

task automatic check_len(input string what, input axi_read_pkg::axi_len_t exp,
	input axi_read_pkg::axi_len_t act);
	if (exp !== act)
		report_failure($sformatf("CHECK FAILED %s: %s expected %0d actual %0d",
			test_name, what, exp, act));
endtask

// single-bit strobes and pending flags
task automatic check_flag(input string what, input logic exp, input logic act);
	if (exp !== act)
		report_failure($sformatf("CHECK FAILED %s: %s expected %b actual %b",
			test_name, what, exp, act));
endtask

/* verif/core_read_port_tb.sv */
`timescale 1ns/1ps

module core_read_port_tb;

	logic clk;
	logic reset;
	logic fetch_strobe;
	core_req_pkg::addr_t fetch_pc;
	logic load_strobe_1;
	core_req_pkg::addr_t load_addr_1;
	logic load_strobe_2;
	core_req_pkg::addr_t load_addr_2;
	logic inst_valid;
	core_req_pkg::word_t inst_1;
	core_req_pkg::word_t inst_2;
	logic load_valid_1;
	core_req_pkg::word_t load_data_1;
	logic load_valid_2;
	core_req_pkg::word_t load_data_2;
	logic fetch_pending;
	logic load_pending_1;
	logic load_pending_2;
	logic arvalid;
	axi_read_pkg::axi_id_t arid;
	core_req_pkg::addr_t araddr;
	axi_read_pkg::axi_len_t arlen;
	logic arready;
	logic rvalid;
	axi_read_pkg::axi_id_t rid;
	core_req_pkg::word_t rdata;

	integer seed;
	int failures;
	string test_name;
	bit stall_on;
	// slave state, indexed by read id
	bit pend_valid [16];
	core_req_pkg::addr_t pend_addr [16];
	axi_read_pkg::axi_len_t pend_len [16];
	axi_read_pkg::axi_id_t return_order [$];
	// accepted address requests, in bus order
	axi_read_pkg::axi_id_t log_id [$];
	core_req_pkg::addr_t log_addr [$];
	axi_read_pkg::axi_len_t log_len [$];
	axi_read_pkg::axi_id_t done_order [$];

	core_read_port i_core_read_port
	(
		.clk            (clk),
		.reset          (reset),
		.fetch_strobe   (fetch_strobe),
		.fetch_pc       (fetch_pc),
		.load_strobe_1  (load_strobe_1),
		.load_addr_1    (load_addr_1),
		.load_strobe_2  (load_strobe_2),
		.load_addr_2    (load_addr_2),
		.inst_valid     (inst_valid),
		.inst_1         (inst_1),
		.inst_2         (inst_2),
		.load_valid_1   (load_valid_1),
		.load_data_1    (load_data_1),
		.load_valid_2   (load_valid_2),
		.load_data_2    (load_data_2),
		.fetch_pending  (fetch_pending),
		.load_pending_1 (load_pending_1),
		.load_pending_2 (load_pending_2),
		.arvalid        (arvalid),
		.arid           (arid),
		.araddr         (araddr),
		.arlen          (arlen),
		.arready        (arready),
		.rvalid         (rvalid),
		.rid            (rid),
		.rdata          (rdata)
	);

	always #50 clk = ~clk;

	task automatic report_failure(input string line);
		failures++;
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	`include "core_read_port_checks.svh"

	//////////////////////////////
	// bus slave model
	//////////////////////////////
	always @(posedge clk)
	begin
		if (arvalid && arready)
		begin
			if (pend_valid[arid])
				report_failure($sformatf("read id %0d accepted while still outstanding", arid));
			pend_valid[arid] = 1'b1;
			pend_addr[arid] = araddr;
			pend_len[arid] = arlen;
			log_id.push_back(arid);
			log_addr.push_back(araddr);
			log_len.push_back(arlen);
		end
	end

	// random stalls only when a test asks for them
	always @(posedge clk)
	begin
		#1;
		if (stall_on)
			arready = ($random(seed) % 3) != 0;
		else
			arready = 1'b1;
	end

	initial
	begin : slave_return
		axi_read_pkg::axi_id_t id;
		bit found;
		int delay;
		forever
		begin
			@(posedge clk);
			#1;
			rvalid = 1'b0;
			found = 1'b0;
			if (return_order.size() > 0)
			begin
				if (pend_valid[return_order[0]])
				begin
					id = return_order.pop_front();
					found = 1'b1;
				end
			end
			else
			begin
				for (int k = 0; k < 3; k++)
				begin
					if (!found && pend_valid[k])
					begin
						id = k;
						found = 1'b1;
					end
				end
			end
			if (found)
			begin
				delay = $unsigned($random(seed)) % 4;
				repeat (delay)
				begin
					@(posedge clk);
					#1;
				end
				for (int i = 0; i <= pend_len[id]; i++)
				begin
					rvalid = 1'b1;
					rid = id;
					rdata = slave_word(pend_addr[id] + i * axi_read_pkg::BEAT_BYTES);
					@(posedge clk);
					#1;
				end
				rvalid = 1'b0;
				pend_valid[id] = 1'b0;
			end
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		log_id.delete();
		log_addr.delete();
		log_len.delete();
	endtask

	// one-cycle strobes, then pending must be up
	task automatic issue(input bit f, input bit l1, input bit l2,
		input core_req_pkg::addr_t pc, input core_req_pkg::addr_t a1,
		input core_req_pkg::addr_t a2);
		fetch_strobe = f;
		fetch_pc = pc;
		load_strobe_1 = l1;
		load_addr_1 = a1;
		load_strobe_2 = l2;
		load_addr_2 = a2;
		next_cycle();
		fetch_strobe = 1'b0;
		load_strobe_1 = 1'b0;
		load_strobe_2 = 1'b0;
		if (f)
			check_flag("fetch_pending after strobe", 1'b1, fetch_pending);
		if (l1)
			check_flag("load_pending_1 after strobe", 1'b1, load_pending_1);
		if (l2)
			check_flag("load_pending_2 after strobe", 1'b1, load_pending_2);
	endtask

	task automatic collect(input bit want_f, input bit want_1, input bit want_2,
		input core_req_pkg::addr_t pc, input core_req_pkg::addr_t a1,
		input core_req_pkg::addr_t a2);
		bit got_f;
		bit got_1;
		bit got_2;
		int n;
		got_f = 1'b0;
		got_1 = 1'b0;
		got_2 = 1'b0;
		n = 0;
		done_order.delete();
		while ((want_f && !got_f) || (want_1 && !got_1) || (want_2 && !got_2))
		begin
			next_cycle();
			n++;
			if (inst_valid)
			begin
				if (!want_f || got_f)
					report_failure($sformatf("%s: unexpected inst_valid strobe", test_name));
				check_word("inst_1", slave_word(pc), inst_1);
				check_word("inst_2", slave_word(pc + axi_read_pkg::BEAT_BYTES), inst_2);
				check_flag("fetch_pending with inst_valid", 1'b0, fetch_pending);
				got_f = 1'b1;
				done_order.push_back(axi_read_pkg::FETCH_ID);
			end
			if (load_valid_1)
			begin
				if (!want_1 || got_1)
					report_failure($sformatf("%s: unexpected load_valid_1 strobe", test_name));
				check_word("load_data_1", slave_word(a1), load_data_1);
				check_flag("load_pending_1 with valid", 1'b0, load_pending_1);
				got_1 = 1'b1;
				done_order.push_back(axi_read_pkg::LOAD_ID_1);
			end
			if (load_valid_2)
			begin
				if (!want_2 || got_2)
					report_failure($sformatf("%s: unexpected load_valid_2 strobe", test_name));
				check_word("load_data_2", slave_word(a2), load_data_2);
				check_flag("load_pending_2 with valid", 1'b0, load_pending_2);
				got_2 = 1'b1;
				done_order.push_back(axi_read_pkg::LOAD_ID_2);
			end
			if (n > 300)
				report_failure($sformatf("%s: timed out waiting for read results", test_name));
		end
	endtask

	task automatic check_request(input int idx, input axi_read_pkg::axi_id_t id,
		input core_req_pkg::addr_t addr, input axi_read_pkg::axi_len_t len);
		if (idx >= log_id.size())
			report_failure($sformatf("%s: address request %0d never seen", test_name, idx));
		check_id("arid", id, log_id[idx]);
		check_addr("araddr", addr, log_addr[idx]);
		check_len("arlen", len, log_len[idx]);
	endtask

	task automatic check_request_count(input int n);
		if (log_id.size() != n)
			report_failure($sformatf("CHECK FAILED %s: request count expected %0d actual %0d",
				test_name, n, log_id.size()));
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic reset_quiet();
		start_test("reset_quiet");
		repeat (5)
		begin
			next_cycle();
			check_flag("arvalid", 1'b0, arvalid);
			check_flag("inst_valid", 1'b0, inst_valid);
			check_flag("load_valid_1", 1'b0, load_valid_1);
			check_flag("load_valid_2", 1'b0, load_valid_2);
			check_flag("fetch_pending", 1'b0, fetch_pending);
			check_flag("load_pending_1", 1'b0, load_pending_1);
			check_flag("load_pending_2", 1'b0, load_pending_2);
		end
		check_request_count(0);
	endtask

	task automatic fetch_pair();
		start_test("fetch_pair");
		issue(1'b1, 1'b0, 1'b0, 32'h0000_1000, '0, '0);
		collect(1'b1, 1'b0, 1'b0, 32'h0000_1000, '0, '0);
		check_request_count(1);
		check_request(0, axi_read_pkg::FETCH_ID, 32'h0000_1000, axi_read_pkg::FETCH_LEN);
	endtask

	task automatic lane_loads();
		start_test("lane_loads");
		issue(1'b0, 1'b1, 1'b0, '0, 32'h0000_2004, '0);
		collect(1'b0, 1'b1, 1'b0, '0, 32'h0000_2004, '0);
		issue(1'b0, 1'b0, 1'b1, '0, '0, 32'h0000_3008);
		collect(1'b0, 1'b0, 1'b1, '0, '0, 32'h0000_3008);
		check_request_count(2);
		check_request(0, axi_read_pkg::LOAD_ID_1, 32'h0000_2004, axi_read_pkg::LOAD_LEN);
		check_request(1, axi_read_pkg::LOAD_ID_2, 32'h0000_3008, axi_read_pkg::LOAD_LEN);
	endtask

	// all three in one cycle, bus order must follow priority
	task automatic fixed_priority();
		start_test("fixed_priority");
		issue(1'b1, 1'b1, 1'b1, 32'h0040_0100, 32'h1000_0010, 32'h1000_0020);
		collect(1'b1, 1'b1, 1'b1, 32'h0040_0100, 32'h1000_0010, 32'h1000_0020);
		check_request_count(3);
		check_request(0, axi_read_pkg::FETCH_ID, 32'h0040_0100, axi_read_pkg::FETCH_LEN);
		check_request(1, axi_read_pkg::LOAD_ID_1, 32'h1000_0010, axi_read_pkg::LOAD_LEN);
		check_request(2, axi_read_pkg::LOAD_ID_2, 32'h1000_0020, axi_read_pkg::LOAD_LEN);
	endtask

	task automatic back_pressure();
		core_req_pkg::addr_t pc;
		core_req_pkg::addr_t a1;
		core_req_pkg::addr_t a2;
		start_test("back_pressure");
		stall_on = 1'b1;
		repeat (4)
		begin
			log_id.delete();
			log_addr.delete();
			log_len.delete();
			pc = core_req_pkg::addr_t'($random(seed)) & 32'hFFFF_FFFC;
			a1 = core_req_pkg::addr_t'($random(seed)) & 32'hFFFF_FFFC;
			a2 = core_req_pkg::addr_t'($random(seed)) & 32'hFFFF_FFFC;
			issue(1'b1, 1'b1, 1'b1, pc, a1, a2);
			collect(1'b1, 1'b1, 1'b1, pc, a1, a2);
			check_request_count(3);
			check_request(0, axi_read_pkg::FETCH_ID, pc, axi_read_pkg::FETCH_LEN);
			check_request(1, axi_read_pkg::LOAD_ID_1, a1, axi_read_pkg::LOAD_LEN);
			check_request(2, axi_read_pkg::LOAD_ID_2, a2, axi_read_pkg::LOAD_LEN);
		end
		stall_on = 1'b0;
	endtask

	// slave answers lane 2, then lane 1, then the fetch pair
	task automatic out_of_order();
		start_test("out_of_order");
		return_order = '{axi_read_pkg::LOAD_ID_2, axi_read_pkg::LOAD_ID_1,
			axi_read_pkg::FETCH_ID};
		issue(1'b1, 1'b1, 1'b1, 32'h0040_0200, 32'h2000_0040, 32'h2000_0080);
		collect(1'b1, 1'b1, 1'b1, 32'h0040_0200, 32'h2000_0040, 32'h2000_0080);
		check_request_count(3);
		check_id("first result", axi_read_pkg::LOAD_ID_2, done_order[0]);
		check_id("second result", axi_read_pkg::LOAD_ID_1, done_order[1]);
		check_id("third result", axi_read_pkg::FETCH_ID, done_order[2]);
	endtask

	initial
	begin
		seed = 34602;
		failures = 0;
		stall_on = 1'b0;
		clk = 1'b0;
		reset = 1'b1;
		fetch_strobe = 1'b0;
		fetch_pc = '0;
		load_strobe_1 = 1'b0;
		load_addr_1 = '0;
		load_strobe_2 = 1'b0;
		load_addr_2 = '0;
		arready = 1'b0;
		rvalid = 1'b0;
		rid = '0;
		rdata = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		reset_quiet();
		fetch_pair();
		lane_loads();
		fixed_priority();
		back_pressure();
		out_of_order();
		if (failures == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
